//--- list.f
+incdir+include
source/ntt_masked_pkg.sv
source/ntt_masked_mult.sv
source/ntt_masked_bfu.sv
source/coeff_mem.sv
source/coeff_mem_arbiter.sv
source/ntt_pass_ctrl.sv
source/ntt_masked_top.sv
verif/ntt_clk_gen.sv
verif/ntt_masked_tb.sv

//--- Bender.yml
package:
  name: ntt_masked

sources:
  - include_dirs:
      - include
    files:
      - source/ntt_masked_pkg.sv
      - source/ntt_masked_mult.sv
      - source/ntt_masked_bfu.sv
      - source/coeff_mem.sv
      - source/coeff_mem_arbiter.sv
      - source/ntt_pass_ctrl.sv
      - source/ntt_masked_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/ntt_clk_gen.sv
      - verif/ntt_masked_tb.sv

//--- verif/ntt_masked_tb.sv
// Directed testbench for the masked NTT butterfly subsystem
// Loads random shares over the host port, runs passes and checks
// every word against an integer model of the butterfly mod q

`default_nettype none

`include "ntt_masked_macros.svh"

module ntt_masked_tb;
    import ntt_masked_pkg::*;

    localparam int     CLK_PERIOD = 100;
    localparam int     NUM_TESTS  = 6;
    localparam int     PASS_LIMIT = 16 * 20;
    localparam longint Q          = `NTT_Q;
    localparam longint WATCHDOG   = (NUM_TESTS * 16 * 20 + 200) * CLK_PERIOD;

    logic                    clk, reset_n;
    logic                    zeroize, start, busy, done;
    logic [1:0]              len_log;
    logic [`NTT_COEFF_W-1:0] zeta, rnd;
    logic                    host_req, host_gnt, host_rvalid;
    mem_req_t                host_mreq;
    masked_coeff_t           host_rdata;

    integer seed = 39518;
    int     errors, checks, share0_changed;
    string  test_name;
    // Unmasked expected contents
    longint                  model [`NTT_MEM_DEPTH];
    // Share0 as it would stand with no mask refresh
    logic [`NTT_COEFF_W-1:0] plain_share0 [`NTT_MEM_DEPTH];

    ntt_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) u_clk (
        .clk     (clk),
        .reset_n (reset_n)
    );

    ntt_masked_top uut (
        .clk         (clk),
        .reset_n     (reset_n),
        .zeroize     (zeroize),
        .start       (start),
        .len_log     (len_log),
        .zeta        (zeta),
        .rnd         (rnd),
        .busy        (busy),
        .done        (done),
        .host_req    (host_req),
        .host_mreq   (host_mreq),
        .host_gnt    (host_gnt),
        .host_rvalid (host_rvalid),
        .host_rdata  (host_rdata)
    );

    function automatic logic [`NTT_COEFF_W-1:0] rand_below_q();
        logic [31:0] r;
        r = $random(seed);
        return r % `NTT_Q;
    endfunction

    function automatic longint recombine(input masked_coeff_t c);
        return (longint'(c.share0) + longint'(c.share1)) % Q;
    endfunction

    // Fresh mask word every cycle
    always @(posedge clk) rnd <= rand_below_q();

    //======================================================================
    // Compare tasks
    //======================================================================
    task automatic compare_bit(input string what, input logic act, input logic exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic compare_coeff(input string what, input masked_coeff_t act, input longint exp);
        checks++;
        if (recombine(act) !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %0d, actual %0d",
                     test_name, what, exp, recombine(act));
        end
    endtask

    // Exact share match for host readback
    task automatic compare_word(input string what, input masked_coeff_t act,
                                input masked_coeff_t exp);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %h/%h, actual %h/%h", test_name, what,
                     exp.share0, exp.share1, act.share0, act.share1);
        end
    endtask

    //======================================================================
    // Host port and model helpers
    //======================================================================
    task automatic host_write(input logic [`NTT_ADDR_W-1:0] addr, input masked_coeff_t data);
        mem_req_t r;
        r.we    = 1'b1;
        r.addr  = addr;
        r.wdata = data;
        @(posedge clk);
        host_req  <= 1'b1;
        host_mreq <= r;
        @(negedge clk);
        compare_bit("write grant", host_gnt, 1'b1);
        @(posedge clk);
        host_req <= 1'b0;
    endtask

    // Grant in the request cycle and rvalid with data one cycle later
    task automatic host_read(input logic [`NTT_ADDR_W-1:0] addr, output masked_coeff_t data);
        mem_req_t r;
        r.we    = 1'b0;
        r.addr  = addr;
        r.wdata = '0;
        @(posedge clk);
        host_req  <= 1'b1;
        host_mreq <= r;
        @(negedge clk);
        compare_bit("read grant", host_gnt, 1'b1);
        compare_bit("rvalid early", host_rvalid, 1'b0);
        @(posedge clk);
        host_req <= 1'b0;
        @(negedge clk);
        compare_bit("read rvalid", host_rvalid, 1'b1);
        data = host_rdata;
    endtask

    // Random split of a value into two shares
    task automatic store_value(input int addr, input longint value);
        masked_coeff_t c;
        c.share0 = rand_below_q();
        c.share1 = (value + Q - c.share0) % Q;
        host_write(addr, c);
        model[addr]        = value;
        plain_share0[addr] = c.share0;
    endtask

    task automatic load_random();
        for (int i = 0; i < `NTT_MEM_DEPTH; i++) store_value(i, rand_below_q());
    endtask

    // Cooley-Tukey pass on plain integers
    task automatic apply_model(input int ll, input longint w);
        int     len;
        longint a, t;
        len = 1 << ll;
        for (int j = 0; j < `NTT_MEM_DEPTH; j++) begin
            if (((j >> ll) & 1) == 0) begin
                a            = model[j];
                t            = (model[j + len] * w) % Q;
                model[j]       = (a + t) % Q;
                model[j + len] = (a + Q - t) % Q;
            end
        end
    endtask

    task automatic check_memory();
        masked_coeff_t rd;
        share0_changed = 0;
        for (int i = 0; i < `NTT_MEM_DEPTH; i++) begin
            host_read(i, rd);
            compare_coeff($sformatf("word %0d", i), rd, model[i]);
            if (rd.share0 !== plain_share0[i]) share0_changed++;
        end
    endtask

    // Start a pass and wait for done with optional host reads mixed in
    task automatic run_pass(input logic [1:0] ll, input logic [`NTT_COEFF_W-1:0] w,
                            input bit host_traffic);
        int       cycles;
        bit       seen_done, prev_req;
        mem_req_t r;
        cycles    = 0;
        seen_done = 0;
        prev_req  = 0;
        @(posedge clk);
        start   <= 1'b1;
        len_log <= ll;
        zeta    <= w;
        @(posedge clk);
        start <= 1'b0;
        while (!seen_done && cycles < PASS_LIMIT) begin
            @(posedge clk);
            if (host_traffic) begin
                r.we      = 1'b0;
                r.addr    = cycles[`NTT_ADDR_W-1:0];
                r.wdata   = '0;
                host_req  <= (cycles % 3 == 1);
                host_mreq <= r;
            end
            @(negedge clk);
            if (host_traffic) begin
                compare_bit("grant in pass", host_gnt, host_req);
                compare_bit("rvalid in pass", host_rvalid, prev_req);
                prev_req = host_req;
            end
            if (done) seen_done = 1;
            else compare_bit("busy", busy, 1'b1);
            cycles++;
        end
        if (!seen_done) begin
            errors++;
            $display("%s: pass gave no done within %0d cycles", test_name, PASS_LIMIT);
        end else begin
            compare_bit("busy at done", busy, 1'b0);
            apply_model(ll, w);
        end
        @(posedge clk);
        host_req <= 1'b0;
        @(negedge clk);
        compare_bit("done width", done, 1'b0);
    endtask

    //======================================================================
    // Directed tests
    //======================================================================
    task automatic check_host_access();
        masked_coeff_t w, rd;
        test_name = "host_rw";
        compare_bit("busy after reset", busy, 1'b0);
        compare_bit("done after reset", done, 1'b0);
        foreach (model[i]) begin
            w.share0 = rand_below_q();
            w.share1 = rand_below_q();
            host_write(i, w);
            host_read(i, rd);
            compare_word($sformatf("word %0d", i), rd, w);
        end
    endtask

    task automatic full_distance_pass();
        test_name = "pass_len8";
        load_random();
        run_pass(2'd3, rand_below_q(), 1'b0);
        check_memory();
    endtask

    task automatic short_distance_passes();
        test_name = "pass_len1_2_4";
        load_random();
        for (int ll = 0; ll < 3; ll++) begin
            run_pass(ll, rand_below_q(), 1'b0);
            check_memory();
        end
    endtask

    task automatic pass_with_host_reads();
        test_name = "pass_host_reads";
        load_random();
        run_pass(2'd1, rand_below_q(), 1'b1);
        check_memory();
    endtask

    task automatic zeroize_mid_pass();
        test_name = "zeroize";
        load_random();
        @(posedge clk);
        start   <= 1'b1;
        len_log <= 2'd3;
        zeta    <= rand_below_q();
        @(posedge clk);
        start <= 1'b0;
        // Roughly two pairs into the pass
        repeat (20) @(posedge clk);
        zeroize <= 1'b1;
        @(negedge clk);
        compare_bit("busy before abort", busy, 1'b1);
        @(posedge clk);
        zeroize <= 1'b0;
        repeat (8) begin
            @(negedge clk);
            compare_bit("busy after abort", busy, 1'b0);
            compare_bit("done after abort", done, 1'b0);
        end
        load_random();
        run_pass(2'd3, rand_below_q(), 1'b0);
        check_memory();
    endtask

    // Unit twiddle, share0 is compared with an unrefreshed share-wise butterfly
    task automatic mask_refresh();
        longint s_a, s_b;
        test_name = "mask_refresh";
        load_random();
        // Share0 that the pass would leave if no rnd were added
        for (int j = 0; j < `NTT_MEM_DEPTH / 2; j++) begin
            s_a = plain_share0[j];
            s_b = plain_share0[j + `NTT_MEM_DEPTH / 2];
            plain_share0[j]                     = (s_a + s_b) % Q;
            plain_share0[j + `NTT_MEM_DEPTH / 2] = (s_a + Q - s_b) % Q;
        end
        run_pass(2'd3, 24'd1, 1'b0);
        check_memory();
        if (share0_changed == 0) begin
            errors++;
            $display("%s: share0 of every word equals the unrefreshed value", test_name);
        end
    endtask

    initial begin
        errors    = 0;
        checks    = 0;
        zeroize   = 1'b0;
        start     = 1'b0;
        len_log   = 2'd0;
        zeta      = '0;
        rnd       = '0;
        host_req  = 1'b0;
        host_mreq = '0;
        wait (reset_n === 1'b1);
        @(negedge clk);
        check_host_access();
        full_distance_pass();
        short_distance_passes();
        pass_with_host_reads();
        zeroize_mid_pass();
        mask_refresh();
        @(posedge clk);
        $display("Closing: %0d errors in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    // Watchdog sized from the test count
    initial begin
        #(WATCHDOG);
        $display("Timeout: run still going after %0d time units", WATCHDOG);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/ntt_clk_gen.sv
// Clock and reset source for the masked NTT testbench
// Reset is held low for a few rising edges, then released

`default_nettype none

module ntt_clk_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic reset_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // Reset low for the first RESET_CYCLES rising edges
    initial begin
        reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset_n <= 1'b1;
    end

endmodule

`default_nettype wire

//--- source/ntt_masked_top.sv
// Top level of the masked NTT butterfly subsystem
// Host port and pass controller share the memory through the arbiter
// zeta must stay stable for the whole pass, rnd is fresh each cycle

`default_nettype none

`include "ntt_masked_macros.svh"

module ntt_masked_top (
    input  wire                             clk,
    input  wire                             reset_n,
    input  wire                             zeroize,
    input  wire                             start,
    input  wire [1:0]                       len_log,
    input  wire [`NTT_COEFF_W-1:0]          zeta,
    input  wire [`NTT_COEFF_W-1:0]          rnd,
    output logic                            busy,
    output logic                            done,
    input  wire                             host_req,
    input  wire ntt_masked_pkg::mem_req_t   host_mreq,
    output logic                            host_gnt,
    output logic                            host_rvalid,
    output ntt_masked_pkg::masked_coeff_t   host_rdata
);
    import ntt_masked_pkg::*;

    // Engine side of the arbiter
    mem_req_t   eng_mreq;
    logic       eng_req, eng_gnt, eng_rvalid;
    // Arbiter to memory
    mem_req_t   mem_req;
    logic       mem_valid;
    // Butterfly handshake
    bfu_pair_t  bfu_pair_in, bfu_pair_out;
    logic       bfu_in_valid, bfu_out_valid;

    ntt_pass_ctrl u_ctrl (
        .clk           (clk),
        .reset_n       (reset_n),
        .zeroize       (zeroize),
        .start         (start),
        .len_log       (len_log),
        .busy          (busy),
        .done          (done),
        .mreq          (eng_mreq),
        .req           (eng_req),
        .gnt           (eng_gnt),
        .rvalid        (eng_rvalid),
        .rdata         (host_rdata),
        .bfu_in_valid  (bfu_in_valid),
        .bfu_pair      (bfu_pair_in),
        .bfu_out_valid (bfu_out_valid),
        .bfu_result    (bfu_pair_out)
    );

    ntt_masked_bfu u_bfu (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (bfu_in_valid),
        .pair_in   (bfu_pair_in),
        .zeta      (zeta),
        .rnd       (rnd),
        .out_valid (bfu_out_valid),
        .pair_out  (bfu_pair_out)
    );

    coeff_mem_arbiter u_arb (
        .clk         (clk),
        .reset_n     (reset_n),
        .host_req    (host_req),
        .host_mreq   (host_mreq),
        .host_gnt    (host_gnt),
        .host_rvalid (host_rvalid),
        .eng_req     (eng_req),
        .eng_mreq    (eng_mreq),
        .eng_gnt     (eng_gnt),
        .eng_rvalid  (eng_rvalid),
        .mem_valid   (mem_valid),
        .mem_req     (mem_req)
    );

    // Read data goes to both peers, rvalid picks the owner
    coeff_mem u_mem (
        .clk     (clk),
        .reset_n (reset_n),
        .valid   (mem_valid),
        .req     (mem_req),
        .rdata   (host_rdata)
    );

endmodule

`default_nettype wire

//--- source/ntt_pass_ctrl.sv
// Pass controller for one butterfly layer over the coefficient memory
// Per pair: read a, read b, run the butterfly, write a', write b'
// Pair distance is 1 << len_log, latched at start

`default_nettype none

`include "ntt_masked_macros.svh"

module ntt_pass_ctrl (
    input  wire                                 clk,
    input  wire                                 reset_n,
    input  wire                                 zeroize,
    input  wire                                 start,
    input  wire [1:0]                           len_log,
    output logic                                busy,
    output logic                                done,
    output ntt_masked_pkg::mem_req_t            mreq,
    output logic                                req,
    input  wire                                 gnt,
    input  wire                                 rvalid,
    input  wire ntt_masked_pkg::masked_coeff_t  rdata,
    output logic                                bfu_in_valid,
    output ntt_masked_pkg::bfu_pair_t           bfu_pair,
    input  wire                                 bfu_out_valid,
    input  wire ntt_masked_pkg::bfu_pair_t      bfu_result
);

    typedef enum logic [2:0] {
        S_IDLE, S_RD_A, S_RD_B, S_WAIT, S_WR_A, S_WR_B
    } state_t;

    state_t                  state;
    logic [`NTT_ADDR_W-1:0]  j, len, addr_b, j_inc, j_next;
    logic [1:0]              len_q;
    logic                    last_pair;

    //======================================================================
    // Index arithmetic and memory request
    //======================================================================
    always_comb begin
        len         = '0;
        len[len_q]  = 1'b1;
        addr_b      = j | len;
        // Skip indices in the upper half of a block
        j_inc       = j + 1'b1;
        j_next      = j_inc[len_q] ? (j_inc + len) : j_inc;
        // Last pair always ends on the top word
        last_pair   = (addr_b == (`NTT_MEM_DEPTH - 1));
        req         = (state != S_IDLE) && (state != S_WAIT);
        mreq.we     = (state == S_WR_A) || (state == S_WR_B);
        mreq.addr   = ((state == S_RD_B) || (state == S_WR_B)) ? addr_b : j;
        mreq.wdata  = (state == S_WR_B) ? bfu_pair.b : bfu_pair.a;
    end

    assign busy = (state != S_IDLE);

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= S_IDLE;
            j            <= '0;
            len_q        <= '0;
            done         <= 1'b0;
            bfu_in_valid <= 1'b0;
        end else if (zeroize) begin
            // Abort without a done pulse
            state        <= S_IDLE;
            j            <= '0;
            len_q        <= '0;
            done         <= 1'b0;
            bfu_in_valid <= 1'b0;
        end else begin
            done         <= 1'b0;
            // b arrives in WAIT, issue the pair the next cycle
            bfu_in_valid <= (state == S_WAIT) && rvalid;
            case (state)
                S_IDLE: if (start) begin
                    j     <= '0;
                    len_q <= len_log;
                    state <= S_RD_A;
                end
                S_RD_A: if (gnt) state <= S_RD_B;
                S_RD_B: if (gnt) state <= S_WAIT;
                S_WAIT: if (bfu_out_valid) state <= S_WR_A;
                S_WR_A: if (gnt) state <= S_WR_B;
                S_WR_B: if (gnt) begin
                    if (last_pair) begin
                        done  <= 1'b1;
                        state <= S_IDLE;
                    end else begin
                        j     <= j_next;
                        state <= S_RD_A;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Operand and result holding register, also the butterfly input
    always_ff @(posedge clk) begin
        if ((state == S_WAIT) && bfu_out_valid) bfu_pair <= bfu_result;
        else if ((state == S_RD_B) && rvalid) bfu_pair.a <= rdata;
        else if ((state == S_WAIT) && rvalid) bfu_pair.b <= rdata;
    end

endmodule

`default_nettype wire

//--- source/coeff_mem_arbiter.sv
// Fixed-priority arbiter in front of the coefficient memory
// Host wins, engine holds its request until granted
// Read data is shared, rvalid tells which peer it belongs to

`default_nettype none

`include "ntt_masked_macros.svh"

module coeff_mem_arbiter (
    input  wire                             clk,
    input  wire                             reset_n,
    input  wire                             host_req,
    input  wire ntt_masked_pkg::mem_req_t   host_mreq,
    output logic                            host_gnt,
    output logic                            host_rvalid,
    input  wire                             eng_req,
    input  wire ntt_masked_pkg::mem_req_t   eng_mreq,
    output logic                            eng_gnt,
    output logic                            eng_rvalid,
    output logic                            mem_valid,
    output ntt_masked_pkg::mem_req_t        mem_req
);

    // Same-cycle grants
    always_comb begin
        host_gnt  = host_req;
        eng_gnt   = eng_req && !host_req;
        mem_valid = host_req || eng_req;
        mem_req   = host_req ? host_mreq : eng_mreq;
    end

    // Owner of last cycle's read, returned as that peer's rvalid
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            host_rvalid <= 1'b0;
            eng_rvalid  <= 1'b0;
        end else begin
            host_rvalid <= host_gnt && !host_mreq.we;
            eng_rvalid  <= eng_gnt && !eng_mreq.we;
        end
    end

endmodule

`default_nettype wire

//--- source/coeff_mem.sv
// Single-port register file of masked coefficients
// Write takes effect at the request edge, read data one cycle later

`default_nettype none

`include "ntt_masked_macros.svh"

module coeff_mem (
    input  wire                             clk,
    input  wire                             reset_n,
    input  wire                             valid,
    input  wire ntt_masked_pkg::mem_req_t   req,
    output ntt_masked_pkg::masked_coeff_t   rdata
);
    import ntt_masked_pkg::*;

    masked_coeff_t mem [`NTT_MEM_DEPTH];

    // Storage array, not cleared by reset or zeroize
    always_ff @(posedge clk) begin
        if (valid && req.we) mem[req.addr] <= req.wdata;
    end

    // Registered read port
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rdata <= '0;
        end else if (valid && !req.we) begin
            rdata <= mem[req.addr];
        end
    end

endmodule

`default_nettype wire

//--- source/ntt_masked_bfu.sv
// Masked Cooley-Tukey butterfly: a' = a + w*b, b' = a - w*b mod q
// Result appears NTT_MULT_LAT + 1 cycles after in_valid, no back-pressure

`default_nettype none

`include "ntt_masked_macros.svh"

module ntt_masked_bfu (
    input  wire                             clk,
    input  wire                             reset_n,
    input  wire                             zeroize,
    input  wire                             in_valid,
    input  wire ntt_masked_pkg::bfu_pair_t  pair_in,
    input  wire [`NTT_COEFF_W-1:0]          zeta,
    input  wire [`NTT_COEFF_W-1:0]          rnd,
    output logic                            out_valid,
    output ntt_masked_pkg::bfu_pair_t       pair_out
);
    import ntt_masked_pkg::*;

    masked_coeff_t t;
    logic          t_valid;
    // Delay line for the a shares, matches the multiplier depth
    masked_coeff_t a_dly [`NTT_MULT_LAT];

    // t = w * b, masked and refreshed
    ntt_masked_mult u_mult (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize   (zeroize),
        .in_valid  (in_valid),
        .x         (pair_in.b),
        .zeta      (zeta),
        .rnd       (rnd),
        .out_valid (t_valid),
        .y         (t)
    );

    // Shifts every cycle so several pairs may be in flight
    always_ff @(posedge clk) begin
        if (zeroize) begin
            for (int i = 0; i < `NTT_MULT_LAT; i++) a_dly[i] <= '0;
        end else begin
            a_dly[0] <= pair_in.a;
            for (int i = 1; i < `NTT_MULT_LAT; i++) a_dly[i] <= a_dly[i-1];
        end
    end

    //======================================================================
    // Final stage, share-wise sum and difference
    //======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else if (zeroize) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= t_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (zeroize) begin
            pair_out <= '0;
        end else if (t_valid) begin
            pair_out.a.share0 <= add_mod(a_dly[`NTT_MULT_LAT-1].share0, t.share0);
            pair_out.a.share1 <= add_mod(a_dly[`NTT_MULT_LAT-1].share1, t.share1);
            pair_out.b.share0 <= sub_mod(a_dly[`NTT_MULT_LAT-1].share0, t.share0);
            pair_out.b.share1 <= sub_mod(a_dly[`NTT_MULT_LAT-1].share1, t.share1);
        end
    end

endmodule

`default_nettype wire

//--- source/ntt_masked_mult.sv
// Share-wise multiplication of a masked coefficient by a public twiddle
// Three register stages: product, reduction mod q, mask refresh with rnd
// Output shares recombine to x * zeta mod q

`default_nettype none

`include "ntt_masked_macros.svh"

module ntt_masked_mult (
    input  wire                                 clk,
    input  wire                                 reset_n,
    input  wire                                 zeroize,
    input  wire                                 in_valid,
    input  wire ntt_masked_pkg::masked_coeff_t  x,
    input  wire [`NTT_COEFF_W-1:0]              zeta,
    input  wire [`NTT_COEFF_W-1:0]              rnd,
    output logic                                out_valid,
    output ntt_masked_pkg::masked_coeff_t       y
);
    import ntt_masked_pkg::*;

    // Stage 1 full products, stage 2 reduced shares
    logic [2*`NTT_COEFF_W-1:0] prod0, prod1;
    logic [2*`NTT_COEFF_W-1:0] rem0, rem1;
    masked_coeff_t             red;
    logic                      valid_s1, valid_s2;

    // Constant-divisor reduction of each 48-bit product
    always_comb begin
        rem0 = prod0 % `NTT_Q;
        rem1 = prod1 % `NTT_Q;
    end

    //======================================================================
    // Valid pipeline
    //======================================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            valid_s1  <= 1'b0;
            valid_s2  <= 1'b0;
            out_valid <= 1'b0;
        end else if (zeroize) begin
            valid_s1  <= 1'b0;
            valid_s2  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_s1  <= in_valid;
            valid_s2  <= valid_s1;
            out_valid <= valid_s2;
        end
    end

    //======================================================================
    // Data pipeline, each stage loads with its own valid
    //======================================================================
    always_ff @(posedge clk) begin
        if (zeroize) begin
            prod0 <= '0;
            prod1 <= '0;
            red   <= '0;
            y     <= '0;
        end else begin
            // Public twiddle, so each share is multiplied on its own
            if (in_valid) begin
                prod0 <= x.share0 * zeta;
                prod1 <= x.share1 * zeta;
            end
            if (valid_s1) begin
                red.share0 <= rem0[`NTT_COEFF_W-1:0];
                red.share1 <= rem1[`NTT_COEFF_W-1:0];
            end
            // Refresh: +r on one share, -r on the other, sum unchanged
            if (valid_s2) begin
                y.share0 <= add_mod(red.share0, rnd);
                y.share1 <= sub_mod(red.share1, rnd);
            end
        end
    end

endmodule

`default_nettype wire

//--- source/ntt_masked_pkg.sv
// Shared types and modular helpers for the masked NTT subsystem
// Import into module bodies, use scoped names in port lists

`default_nettype none

`include "ntt_masked_macros.svh"

package ntt_masked_pkg;

    // Two additive shares, value = share0 + share1 mod q
    typedef struct packed {
        logic [`NTT_COEFF_W-1:0] share0;
        logic [`NTT_COEFF_W-1:0] share1;
    } masked_coeff_t;

    // Single-port memory request, shared by both peers
    typedef struct packed {
        logic                    we;
        logic [`NTT_ADDR_W-1:0]  addr;
        masked_coeff_t           wdata;
    } mem_req_t;

    // Butterfly operand pair, a is the low index, b the high index
    typedef struct packed {
        masked_coeff_t a;
        masked_coeff_t b;
    } bfu_pair_t;

    // Modular add, both inputs already below q
    function automatic logic [`NTT_COEFF_W-1:0] add_mod(
        input logic [`NTT_COEFF_W-1:0] x,
        input logic [`NTT_COEFF_W-1:0] y
    );
        logic [`NTT_COEFF_W:0] s;
        s = x + y;
        if (s >= `NTT_Q) s = s - `NTT_Q;
        return s[`NTT_COEFF_W-1:0];
    endfunction

    // Modular subtract, adds q first so the sum never goes negative
    function automatic logic [`NTT_COEFF_W-1:0] sub_mod(
        input logic [`NTT_COEFF_W-1:0] x,
        input logic [`NTT_COEFF_W-1:0] y
    );
        logic [`NTT_COEFF_W:0] d;
        d = x + `NTT_Q - y;
        if (d >= `NTT_Q) d = d - `NTT_Q;
        return d[`NTT_COEFF_W-1:0];
    endfunction

endpackage

`default_nettype wire

//--- include/ntt_masked_macros.svh
// Global constants for the masked NTT butterfly subsystem
// Included by the package, every RTL file and the testbench
// Modulus and widths follow the ML-DSA coefficient ring

`ifndef NTT_MASKED_MACROS_SVH
`define NTT_MASKED_MACROS_SVH

// ML-DSA prime modulus, fits in one share word
`define NTT_Q 24'd8380417

// Width of one additive share
`define NTT_COEFF_W 24

// Coefficient memory geometry
`define NTT_MEM_DEPTH 16
`define NTT_ADDR_W 4

// Pipeline depth of the masked multiplier
`define NTT_MULT_LAT 3

`endif
